/* verilog/ahbApbPkg.sv */
// Bridge-wide sizes and encodings.
// The bridge window must be aligned to 256 MiB and holds three 64 MiB regions.
package ahbApbPkg;

	localparam int addrWidth  = 32;
	localparam int dataWidth  = 32;
	localparam int numSlaves  = 3; // width of Pselx.
	localparam int regionBits = 26; // region offset bits, 64 MiB each.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AHB transfer types, HTRANS encoding.
	typedef enum logic [1:0]
	{
		transIdle   = 2'b00,
		transBusy   = 2'b01,
		transNonseq = 2'b10,
		transSeq    = 2'b11
	} ahbTrans;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB phase sequencer states.
	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001, // write data phase on AHB.
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100, // another transfer already accepted.
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenableP = 3'b111
	} apbState;

endpackage

/* verilog/ahbSlaveInterface.sv */
// AHB side of the bridge: accepts single transfers and decodes the peripheral.
// Stage one registers only move while Hreadyin is high, so they keep the last
// accepted phase over bridge wait states. Stage two follows stage one each cycle.
module ahbSlaveInterface
#(
	parameter logic [ahbApbPkg::addrWidth-1:0] bridgeBase = 32'h8000_0000
)
(
	input  logic                            Hclk,
	input  logic                            Hresetn,
	input  ahbApbPkg::ahbTrans              Htrans,
	input  logic                            Hwrite,
	input  logic                            Hreadyin,
	input  logic [ahbApbPkg::addrWidth-1:0] Haddr,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata,
	output logic                            valid,
	output logic                            Hwritereg,
	output logic [ahbApbPkg::addrWidth-1:0] Haddr1,
	output logic [ahbApbPkg::addrWidth-1:0] Haddr2,
	output logic [ahbApbPkg::dataWidth-1:0] Hwdata1,
	output logic [ahbApbPkg::dataWidth-1:0] Hwdata2,
	output logic [ahbApbPkg::numSlaves-1:0] tempselx
);

	import ahbApbPkg::*;

	// window tag sits above the two region index bits.
	localparam int windowLsb = regionBits + 2;

	logic [1:0] regionIdx;
	logic       inWindow;
	logic       activeTrans;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address decode

	assign regionIdx = Haddr[windowLsb-1:regionBits];
	assign inWindow  = (Haddr[addrWidth-1:windowLsb] == bridgeBase[addrWidth-1:windowLsb]);

	// only nonseq and seq carry a transfer.
	assign activeTrans = (Htrans == transNonseq) || (Htrans == transSeq);

	always_comb
	begin
		for (int i = 0; i < numSlaves; i++)
		begin
			tempselx[i] = inWindow && (regionIdx == 2'(i));
		end
	end

	// the fourth region of the window is unmapped, tempselx stays zero there.
	assign valid = Hreadyin && activeTrans && (|tempselx);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline registers

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Hwritereg <= 1'b0;
		end
		else if (Hreadyin)
		begin
			Hwritereg <= Hwrite; // direction of last accepted phase.
		end
	end

	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
		begin
			Haddr1  <= Haddr;
			Hwdata1 <= Hwdata; // data phase completes on this edge.
		end
		Haddr2  <= Haddr1;
		Hwdata2 <= Hwdata1;
	end

endmodule

/* verilog/apbController.sv */
// APB phase sequencer. Every APB output and Hreadyout comes from a flop.
// No Pready, so each setup and enable phase lasts exactly one cycle.
// Relies on Hreadyin being the bridge's own Hreadyout.
module apbController
(
	input  logic                            Hclk,
	input  logic                            Hresetn,
	input  logic                            valid,
	input  logic                            Hwrite,
	input  logic                            Hwritereg,
	input  logic [ahbApbPkg::addrWidth-1:0] Haddr,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata,
	input  logic [ahbApbPkg::addrWidth-1:0] Haddr1,
	input  logic [ahbApbPkg::addrWidth-1:0] Haddr2,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata1,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata2,
	input  logic [ahbApbPkg::numSlaves-1:0] tempselx,
	output logic                            Pwrite,
	output logic                            Penable,
	output logic [ahbApbPkg::numSlaves-1:0] Pselx,
	output logic [ahbApbPkg::addrWidth-1:0] Paddr,
	output logic [ahbApbPkg::dataWidth-1:0] Pwdata,
	output logic                            Hreadyout
);

	import ahbApbPkg::*;

	apbState presentState;
	apbState nextState;

	logic [numSlaves-1:0] selx1; // select of last accepted phase.
	logic [numSlaves-1:0] selx2;

	logic                 PwriteNext;
	logic                 PenableNext;
	logic [numSlaves-1:0] PselxNext;
	logic [addrWidth-1:0] PaddrNext;
	logic [dataWidth-1:0] PwdataNext;
	logic                 HreadyoutNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state

	always_comb
	begin
		case (presentState)
			stIdle, stRenable, stWenable:
			begin
				if (!valid)
					nextState = stIdle;
				else if (Hwrite)
					nextState = stWwait;
				else
					nextState = stRead;
			end
			stWwait:
			begin
				if (!valid)
					nextState = stWrite;
				else
					nextState = stWriteP;
			end
			stRead:
			begin
				nextState = stRenable;
			end
			stWrite:
			begin
				// valid is low here since Hreadyout is low.
				if (!valid)
					nextState = stWenable;
				else
					nextState = stWenableP;
			end
			stWriteP:
			begin
				nextState = stWenableP;
			end
			stWenableP:
			begin
				if (!Hwritereg)
					nextState = stRead;
				else if (!valid)
					nextState = stWrite;
				else
					nextState = stWriteP;
			end
			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next APB outputs

	always_comb
	begin
		PwriteNext    = Pwrite;
		PenableNext   = 1'b0;
		PselxNext     = '0;
		PaddrNext     = Paddr;
		PwdataNext    = Pwdata;
		HreadyoutNext = 1'b1;

		case (presentState)
			stIdle, stRenable, stWenable:
			begin
				if (valid && !Hwrite)
				begin
					// read setup straight from the address phase.
					PaddrNext     = Haddr;
					PselxNext     = tempselx;
					PwriteNext    = 1'b0;
					HreadyoutNext = 1'b0;
				end
				else
				begin
					PwriteNext = 1'b0; // writes wait for their data phase.
				end
			end
			stWwait:
			begin
				PaddrNext     = Haddr1;
				PwdataNext    = Hwdata; // data phase of that write.
				PselxNext     = selx1;
				PwriteNext    = 1'b1;
				HreadyoutNext = 1'b0;
			end
			stRead:
			begin
				PselxNext   = Pselx;
				PenableNext = 1'b1; // Hrdata is Prdata in this cycle.
			end
			stWrite:
			begin
				PselxNext   = Pselx;
				PwdataNext  = Hwdata1;
				PenableNext = 1'b1;
			end
			stWriteP:
			begin
				PselxNext     = Pselx;
				PwdataNext    = Hwdata1;
				PenableNext   = 1'b1;
				HreadyoutNext = Hwritereg; // a pending read holds its data phase.
			end
			stWenableP:
			begin
				PaddrNext     = Haddr2;
				PselxNext     = selx2;
				HreadyoutNext = 1'b0;
				if (Hwritereg)
				begin
					PwriteNext = 1'b1;
					PwdataNext = Hwdata;
				end
				else
				begin
					PwriteNext = 1'b0;
					PwdataNext = Hwdata2; // keep the last write data.
				end
			end
			default:
			begin
				PwriteNext = 1'b0;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registers

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			presentState <= stIdle;
			Pwrite       <= 1'b0;
			Penable      <= 1'b0;
			Pselx        <= '0;
			Hreadyout    <= 1'b0;
		end
		else
		begin
			presentState <= nextState;
			Pwrite       <= PwriteNext;
			Penable      <= PenableNext;
			Pselx        <= PselxNext;
			Hreadyout    <= HreadyoutNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr  <= PaddrNext;
		Pwdata <= PwdataNext;
		if (valid)
		begin
			selx1 <= tempselx;
		end
		selx2 <= selx1; // lines up with Haddr2.
	end

endmodule

/* verilog/ahbApbBridge.sv */
// AHB-Lite to APB bridge for a single master and three APB2 peripherals.
// No Pready, no Hresp. Hreadyin must be tied to Hreadyout.
module ahbApbBridge
#(
	parameter logic [ahbApbPkg::addrWidth-1:0] bridgeBase = 32'h8000_0000
)
(
	input  logic                            Hclk,
	input  logic                            Hresetn,
	input  ahbApbPkg::ahbTrans              Htrans,
	input  logic                            Hwrite,
	input  logic                            Hreadyin,
	input  logic [ahbApbPkg::addrWidth-1:0] Haddr,
	input  logic [ahbApbPkg::dataWidth-1:0] Hwdata,
	output logic                            Hreadyout,
	output logic [ahbApbPkg::dataWidth-1:0] Hrdata,
	output logic [ahbApbPkg::numSlaves-1:0] Pselx,
	output logic                            Penable,
	output logic                            Pwrite,
	output logic [ahbApbPkg::addrWidth-1:0] Paddr,
	output logic [ahbApbPkg::dataWidth-1:0] Pwdata,
	input  logic [ahbApbPkg::dataWidth-1:0] Prdata
);

	import ahbApbPkg::*;

	logic                 valid;
	logic                 Hwritereg;
	logic [addrWidth-1:0] Haddr1;
	logic [addrWidth-1:0] Haddr2;
	logic [dataWidth-1:0] Hwdata1;
	logic [dataWidth-1:0] Hwdata2;
	logic [numSlaves-1:0] tempselx;

	ahbSlaveInterface
	#(
		.bridgeBase (bridgeBase)
	)
	ahbSlaveInterface_i
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hreadyin  (Hreadyin),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.valid     (valid),
		.Hwritereg (Hwritereg),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata1   (Hwdata1),
		.Hwdata2   (Hwdata2),
		.tempselx  (tempselx)
	);

	apbController apbController_i
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.Hwrite    (Hwrite),
		.Hwritereg (Hwritereg),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata1   (Hwdata1),
		.Hwdata2   (Hwdata2),
		.tempselx  (tempselx),
		.Pwrite    (Pwrite),
		.Penable   (Penable),
		.Pselx     (Pselx),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Hreadyout (Hreadyout)
	);

	// sampled by the master in the enable cycle.
	assign Hrdata = Prdata;

endmodule

/* test/ahbApbBridgeTb.sv */
// Random single AHB transfers against a model of three APB peripherals.
// Hreadyin follows Hreadyout, except for one-cycle stalls from another slave.
// Peripheral memories hold 16 words each, indexed by Paddr[5:2].
module ahbApbBridgeTb;

	import ahbApbPkg::*;

	localparam logic [addrWidth-1:0] windowBase = 32'h8000_0000; // DUT default.
	localparam int numTransfers = 400;
	localparam int cycleLimit   = numTransfers * 6 + 100;
	localparam int windowLsb    = regionBits + 2;

	typedef struct
	{
		logic [numSlaves-1:0] sel;
		logic [addrWidth-1:0] addr;
		logic                 write;
		logic [dataWidth-1:0] data; // write data, or expected read data.
		int                   setupAt; // -1 when the timing is not fixed.
	} apbXfer;

	logic                 Hclk;
	logic                 Hresetn;
	ahbTrans              Htrans;
	logic                 Hwrite;
	logic                 Hreadyin;
	logic [addrWidth-1:0] Haddr;
	logic [dataWidth-1:0] Hwdata;
	logic                 Hreadyout;
	logic [dataWidth-1:0] Hrdata;
	logic [numSlaves-1:0] Pselx;
	logic                 Penable;
	logic                 Pwrite;
	logic [addrWidth-1:0] Paddr;
	logic [dataWidth-1:0] Pwdata;
	logic [dataWidth-1:0] Prdata;

	logic [dataWidth-1:0] periMem [0:63]; // {slot, word}.
	logic [dataWidth-1:0] refMem [0:63];
	logic [1:0]           periSlot;
	apbXfer               expQ [$];
	apbXfer               setupXfer;
	logic [dataWidth-1:0] setupPwdata;
	logic                 inSetup;
	logic                 foreignStall;
	logic                 prevWrite;
	logic [dataWidth-1:0] prevWdata;
	logic                 prevBridge;
	int                   cycles;

	initial
	begin
		Hclk = 1'b0;
		forever #5 Hclk = ~Hclk;
	end

	ahbApbBridge ahbApbBridge_i
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hreadyin  (Hreadyin),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.Hreadyout (Hreadyout),
		.Hrdata    (Hrdata),
		.Pselx     (Pselx),
		.Penable   (Penable),
		.Pwrite    (Pwrite),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata),
		.Prdata    (Prdata)
	);

	assign Hreadyin = (Hreadyout === 1'b1) && !foreignStall; // single slave tie.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB peripherals

	assign periSlot = Pselx[2] ? 2'd2 : (Pselx[1] ? 2'd1 : 2'd0);
	assign Prdata   = ((|Pselx) === 1'b1) ? periMem[{periSlot, Paddr[5:2]}] : '0;

	always @(posedge Hclk)
	begin
		if (Hresetn && Penable && Pwrite && ((|Pselx) === 1'b1))
			periMem[{periSlot, Paddr[5:2]}] <= Pwdata;
	end

	always @(posedge Hclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
			abortRun($sformatf("timeout: the run did not complete in %0d cycles", cycleLimit));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkSel(input string name, input logic [numSlaves-1:0] got,
		input logic [numSlaves-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic checkAddr(input string name, input logic [addrWidth-1:0] got,
		input logic [addrWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkWdata(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkRdata(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic checkResetOutputs(input logic readyExp);
		checkSel("Pselx", Pselx, '0);
		checkFlag("Penable", Penable, 1'b0);
		checkFlag("Pwrite", Pwrite, 1'b0);
		checkFlag("Hreadyout", Hreadyout, readyExp);
	endtask

	// called on every falling edge while APB outputs are stable.
	task automatic checkApbCycle();
		apbXfer x;
		if (inSetup)
		begin
			checkFlag("Penable", Penable, 1'b1);
			checkSel("Pselx", Pselx, setupXfer.sel);
			checkAddr("Paddr", Paddr, setupXfer.addr);
			checkFlag("Pwrite", Pwrite, setupXfer.write);
			checkWdata("Pwdata", Pwdata, setupPwdata);
			if (!setupXfer.write)
			begin
				checkFlag("Hreadyout", Hreadyout, 1'b1);
				checkRdata("Hrdata", Hrdata, setupXfer.data);
			end
			inSetup = 1'b0;
		end
		else if (Penable !== 1'b0)
			abortRun("Penable went high without a setup cycle before it");
		else if (Pselx !== '0)
		begin
			if (expQ.size() == 0)
				abortRun("an APB transfer appeared that no AHB transfer asked for");
			else
			begin
				x = expQ.pop_front();
				checkSel("Pselx", Pselx, x.sel);
				checkAddr("Paddr", Paddr, x.addr);
				checkFlag("Pwrite", Pwrite, x.write);
				if (x.write)
					checkWdata("Pwdata", Pwdata, x.data);
				if (x.setupAt >= 0 && cycles != x.setupAt)
					abortRun($sformatf("read setup came in cycle %0d instead of cycle %0d",
						cycles, x.setupAt));
				setupXfer   = x;
				setupPwdata = Pwdata;
				inSetup     = 1'b1;
			end
		end
	endtask

	always @(negedge Hclk)
	begin
		if (Hresetn)
			checkApbCycle();
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and AHB master

	function automatic logic [dataWidth-1:0] fillWord(input int a);
		return 32'h5a5a_0000 ^ (a * 32'h0001_0203);
	endfunction

	// queues the APB transfer an accepted phase must produce, if any.
	function automatic logic recordPhase(input ahbTrans trans, input logic write,
		input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] wdata);
		apbXfer x;
		logic   mapped;
		int     slot;
		int     word;
		slot   = addr[windowLsb-1:regionBits];
		word   = slot * 16 + addr[5:2];
		mapped = ((trans == transNonseq) || (trans == transSeq)) && (slot < numSlaves)
			&& (addr[addrWidth-1:windowLsb] == windowBase[addrWidth-1:windowLsb]);
		if (mapped)
		begin
			x.sel       = '0;
			x.sel[slot] = 1'b1;
			x.addr      = addr;
			x.write     = write;
			x.setupAt   = (!write && expQ.size() == 0) ? cycles + 1 : -1; // bridge idle.
			if (write)
				refMem[word] = wdata;
			x.data = refMem[word];
			expQ.push_back(x);
		end
		return mapped;
	endfunction

	// address phase plus data of the phase before, held until taken.
	task automatic runPhase(input ahbTrans trans, input logic write,
		input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] wdata);
		Htrans       = trans;
		Hwrite       = write;
		Haddr        = addr;
		Hwdata       = prevWrite ? prevWdata : dataWidth'($urandom());
		foreignStall = !prevBridge && ($urandom_range(7) == 0); // other slave's data phase.
		while (!((Hreadyout === 1'b1) && !foreignStall))
		begin
			@(negedge Hclk);
			foreignStall = 1'b0;
		end
		prevBridge = recordPhase(trans, write, addr, wdata);
		prevWrite  = write;
		prevWdata  = wdata;
		@(negedge Hclk);
	endtask

	initial
	begin
		int                   pick;
		int                   slot;
		ahbTrans              trans;
		logic                 write;
		logic [addrWidth-1:0] addr;
		void'($urandom(32'h3905_a81d));
		Hresetn      = 1'b0;
		Htrans       = transIdle;
		Hwrite       = 1'b0;
		Haddr        = '0;
		Hwdata       = '0;
		foreignStall = 1'b0;
		prevWrite    = 1'b0;
		prevWdata    = '0;
		prevBridge   = 1'b0;
		inSetup      = 1'b0;
		cycles       = 0;
		for (int i = 0; i < 64; i++)
		begin
			periMem[i] = fillWord(i);
			refMem[i]  = fillWord(i);
		end
		repeat (2)
		begin
			@(negedge Hclk);
			checkResetOutputs(1'b0);
		end
		Hresetn = 1'b1;
		@(negedge Hclk);
		checkResetOutputs(1'b1);

		for (int n = 0; n < numTransfers; n++)
		begin
			pick = $urandom_range(15);
			if (pick == 0)
				trans = transIdle;
			else if (pick == 1)
				trans = transBusy;
			else if (pick[0])
				trans = transSeq;
			else
				trans = transNonseq;
			write = ($urandom_range(9) < 6); // leans to runs of writes.
			pick  = $urandom_range(15);
			if (pick == 0)
				addr = $urandom(); // mostly outside the window.
			else
			begin
				slot = (pick == 1) ? 3 : $urandom_range(2); // slot 3 is unmapped.
				addr = windowBase | (addrWidth'(slot) << regionBits)
					| ($urandom() & 32'h03ff_ffc0) | (addrWidth'($urandom_range(15)) << 2);
			end
			runPhase(trans, write, addr, dataWidth'($urandom()));
		end

		// idle phases until the last enable cycle has passed, at most eight.
		for (int k = 0; k < 8 && (expQ.size() != 0 || inSetup); k++)
			runPhase(transIdle, 1'b0, '0, '0);

		if (expQ.size() != 0 || inSetup)
			abortRun("expected APB transfers were still missing at the end of the run");
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* src.f */
verilog/ahbApbPkg.sv
verilog/ahbSlaveInterface.sv
verilog/apbController.sv
verilog/ahbApbBridge.sv
test/ahbApbBridgeTb.sv

/* Bender.yml */
package:
  name: ahb_apb_bridge

sources:
  - files:
      - verilog/ahbApbPkg.sv
      - verilog/ahbSlaveInterface.sv
      - verilog/apbController.sv
      - verilog/ahbApbBridge.sv
  - target: test
    files:
      - test/ahbApbBridgeTb.sv
